/* design/cache_pkg.sv */
package cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int NUM_SETS       = 8;
	localparam int WORDS_PER_LINE = 8;
	localparam int WORD_BITS      = 16;

	// Field positions in a processor address.
	localparam int OFFSET_LSB = 1; // Bit 0 picks a byte and is ignored.
	localparam int SET_LSB    = 4;
	localparam int TAG_LSB    = 7;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [15:0] addr_t;
	typedef logic [8:0]  tag_t;
	typedef logic [2:0]  set_t;
	typedef logic [2:0]  offset_t;

	typedef logic [WORD_BITS-1:0]                word_t;
	typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

	typedef logic [15:0] count_t; // Statistics counter.

	typedef enum logic [2:0] {
		idle,
		read,
		write,
		read_from_mem, // Line fill.
		write_to_mem   // Write-back of a dirty victim.
	} ctrl_state_t;

endpackage

/* design/cache_way.sv */
module cache_way #(
	parameter int num_sets = cache_pkg::NUM_SETS
) (
	input  logic             clk,
	input  logic             reset_hits,
	input  cache_pkg::set_t  set,
	input  cache_pkg::tag_t  tag_in,
	input  cache_pkg::line_t line_in,
	input  logic             valid_write,
	input  logic             tag_write,
	input  logic             data_write,
	input  logic             dirty_write,
	input  logic             dirty_write_val,
	output logic             hit,
	output logic             dirty,
	output logic             valid,
	output cache_pkg::tag_t  tag_out,
	output cache_pkg::line_t line_out
);
	import cache_pkg::*;

	tag_t  tag_array  [num_sets];
	line_t data_array [num_sets];

	logic [num_sets-1:0] valid_bits;
	logic [num_sets-1:0] dirty_bits;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Status bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset_hits) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else begin
			if (valid_write) begin
				valid_bits[set] <= 1'b1; // Lines are never invalidated.
			end
			if (dirty_write) begin
				dirty_bits[set] <= dirty_write_val;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tag and data arrays
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (tag_write) begin
			tag_array[set] <= tag_in;
		end
		if (data_write) begin
			data_array[set] <= line_in;
		end
	end

	// Addressed set is read without a clock.
	assign tag_out  = tag_array[set];
	assign line_out = data_array[set];
	assign valid    = valid_bits[set];
	assign dirty    = dirty_bits[set];

	assign hit = valid && (tag_out == tag_in);

endmodule

/* design/cache_control.sv */
module cache_control (
	input  logic              clk,
	input  logic              reset_hits,
	input  logic              mem_read,
	input  logic              mem_write,
	input  logic              found,
	input  logic              victim_dirty,
	input  logic              pmem_resp,
	output logic              mem_resp,
	output logic              pmem_read,
	output logic              pmem_write,
	output logic              lru_write,
	output logic              valid_write,
	output logic              data_write,
	output logic              tag_write,
	output logic              dirty_write,
	output logic              dirty_write_val,
	output logic              fill_sel,
	output logic              wb_addr_sel,
	output cache_pkg::count_t hit_count,
	output cache_pkg::count_t miss_count
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	count_t      resp_count; // Every completed request, hit or miss.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State register and next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset_hits) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (mem_read) begin
					next_state = read;
				end else if (mem_write) begin
					next_state = write;
				end
			end
			read, write: begin
				if (found) begin
					next_state = idle;
				end else if (victim_dirty) begin
					next_state = write_to_mem;
				end else begin
					next_state = read_from_mem;
				end
			end
			write_to_mem: begin
				if (pmem_resp) begin
					next_state = read_from_mem;
				end
			end
			read_from_mem: begin
				// Back to the lookup that missed, which now hits.
				if (pmem_resp) begin
					next_state = mem_write ? write : read;
				end
			end
			default: next_state = idle;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		mem_resp        = 1'b0;
		pmem_read       = 1'b0;
		pmem_write      = 1'b0;
		lru_write       = 1'b0;
		valid_write     = 1'b0;
		data_write      = 1'b0;
		tag_write       = 1'b0;
		dirty_write     = 1'b0;
		dirty_write_val = 1'b0;
		fill_sel        = 1'b0;
		wb_addr_sel     = 1'b0;
		case (state)
			read: begin
				mem_resp  = found;
				lru_write = found;
			end
			write: begin
				mem_resp        = found;
				lru_write       = found;
				data_write      = found; // Word insert into the hitting line.
				dirty_write     = found;
				dirty_write_val = 1'b1;
			end
			write_to_mem: begin
				pmem_write  = 1'b1;
				wb_addr_sel = 1'b1;
				dirty_write = pmem_resp; // Victim is clean once memory has it.
			end
			read_from_mem: begin
				pmem_read   = 1'b1;
				fill_sel    = 1'b1;
				tag_write   = pmem_resp;
				data_write  = pmem_resp;
				valid_write = pmem_resp;
				dirty_write = pmem_resp;
			end
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Statistics
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset_hits) begin
			resp_count <= '0;
			miss_count <= '0;
		end else begin
			if (mem_resp) begin
				resp_count <= resp_count + 1'b1;
			end
			if (state == read_from_mem && pmem_resp) begin
				miss_count <= miss_count + 1'b1;
			end
		end
	end

	// A missed request also answers once, after its fill.
	assign hit_count = resp_count - miss_count;

	// A memory command stays up until its response.
	a_pmem_cmd_held: assert property (@(posedge clk) disable iff (reset_hits)
		(pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write}));

	a_resp_needs_request: assert property (@(posedge clk) disable iff (reset_hits)
		mem_resp |-> (mem_read || mem_write));

endmodule

/* design/cache_datapath.sv */
module cache_datapath #(
	parameter int num_sets = cache_pkg::NUM_SETS
) (
	input  logic             clk,
	input  logic             reset_hits,
	input  cache_pkg::addr_t mem_address,
	input  cache_pkg::word_t mem_wdata,
	input  cache_pkg::line_t pmem_rdata,
	input  logic             lru_write,
	input  logic             valid_write,
	input  logic             data_write,
	input  logic             tag_write,
	input  logic             dirty_write,
	input  logic             dirty_write_val,
	input  logic             fill_sel,
	input  logic             wb_addr_sel,
	output logic             found,
	output logic             victim_dirty,
	output cache_pkg::word_t mem_rdata,
	output cache_pkg::addr_t pmem_address,
	output cache_pkg::line_t pmem_wdata
);
	import cache_pkg::*;

	tag_t    tag;
	set_t    set;
	offset_t offset;

	logic [1:0] way_hit;
	logic [1:0] way_dirty;
	logic [1:0] way_valid;
	logic [1:0] way_en; // One-hot write enable for the selected way.
	tag_t       way_tag  [2];
	line_t      way_line [2];

	logic [num_sets-1:0] lru_bits; // Per set, the way to replace next.

	logic  lru_way;
	logic  sel_way;
	tag_t  sel_tag;
	tag_t  line_tag;
	line_t sel_line;
	line_t write_line;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address split and way select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign tag    = mem_address[TAG_LSB +: $bits(tag_t)];
	assign set    = mem_address[SET_LSB +: $bits(set_t)];
	assign offset = mem_address[OFFSET_LSB +: $bits(offset_t)];

	assign found   = |way_hit;
	assign lru_way = lru_bits[set];
	assign sel_way = found ? way_hit[1] : lru_way; // Victim on a miss.
	assign way_en  = {sel_way, ~sel_way};

	assign sel_tag  = way_tag[sel_way];
	assign sel_line = way_line[sel_way];

	assign victim_dirty = way_valid[lru_way] & way_dirty[lru_way];

	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_way #(
			.num_sets (num_sets)
		) u_way (
			.clk             (clk),
			.reset_hits      (reset_hits),
			.set             (set),
			.tag_in          (tag),
			.line_in         (write_line),
			.valid_write     (valid_write & way_en[w]),
			.tag_write       (tag_write & way_en[w]),
			.data_write      (data_write & way_en[w]),
			.dirty_write     (dirty_write & way_en[w]),
			.dirty_write_val (dirty_write_val),
			.hit             (way_hit[w]),
			.dirty           (way_dirty[w]),
			.valid           (way_valid[w]),
			.tag_out         (way_tag[w]),
			.line_out        (way_line[w])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word insert and extract
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		if (fill_sel) begin
			write_line = pmem_rdata;
		end else begin
			write_line = sel_line;
			write_line[offset * WORD_BITS +: WORD_BITS] = mem_wdata;
		end
	end

	assign mem_rdata = sel_line[offset * WORD_BITS +: WORD_BITS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Write-back goes to the victim's own line.
	assign line_tag     = wb_addr_sel ? sel_tag : tag;
	assign pmem_address = {line_tag, set, offset_t'(0), 1'b0};
	assign pmem_wdata   = sel_line;

	always_ff @(posedge clk) begin
		if (reset_hits) begin
			lru_bits <= '0;
		end else if (lru_write) begin
			lru_bits[set] <= ~sel_way; // Point at the other way.
		end
	end

	a_one_way_hits: assert property (@(posedge clk) disable iff (reset_hits)
		!(way_hit[0] && way_hit[1]));

endmodule

/* design/cache.sv */
module cache #(
	parameter int num_sets = cache_pkg::NUM_SETS
) (
	input  logic              clk,
	input  logic              reset_hits,
	input  logic              mem_read,
	input  logic              mem_write,
	input  cache_pkg::addr_t  mem_address,
	input  cache_pkg::word_t  mem_wdata,
	output logic              mem_resp,
	output cache_pkg::word_t  mem_rdata,
	output logic              pmem_read,
	output logic              pmem_write,
	output cache_pkg::addr_t  pmem_address,
	output cache_pkg::line_t  pmem_wdata,
	input  logic              pmem_resp,
	input  cache_pkg::line_t  pmem_rdata,
	output cache_pkg::count_t hit_count,
	output cache_pkg::count_t miss_count
);

	// Controller to datapath strobes.
	logic lru_write;
	logic valid_write;
	logic data_write;
	logic tag_write;
	logic dirty_write;
	logic dirty_write_val;
	logic fill_sel;
	logic wb_addr_sel;

	// Datapath status back to the controller.
	logic found;
	logic victim_dirty;

	cache_control u_control (
		.clk             (clk),
		.reset_hits      (reset_hits),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.found           (found),
		.victim_dirty    (victim_dirty),
		.pmem_resp       (pmem_resp),
		.mem_resp        (mem_resp),
		.pmem_read       (pmem_read),
		.pmem_write      (pmem_write),
		.lru_write       (lru_write),
		.valid_write     (valid_write),
		.data_write      (data_write),
		.tag_write       (tag_write),
		.dirty_write     (dirty_write),
		.dirty_write_val (dirty_write_val),
		.fill_sel        (fill_sel),
		.wb_addr_sel     (wb_addr_sel),
		.hit_count       (hit_count),
		.miss_count      (miss_count)
	);

	cache_datapath #(
		.num_sets (num_sets)
	) u_datapath (
		.clk             (clk),
		.reset_hits      (reset_hits),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.pmem_rdata      (pmem_rdata),
		.lru_write       (lru_write),
		.valid_write     (valid_write),
		.data_write      (data_write),
		.tag_write       (tag_write),
		.dirty_write     (dirty_write),
		.dirty_write_val (dirty_write_val),
		.fill_sel        (fill_sel),
		.wb_addr_sel     (wb_addr_sel),
		.found           (found),
		.victim_dirty    (victim_dirty),
		.mem_rdata       (mem_rdata),
		.pmem_address    (pmem_address),
		.pmem_wdata      (pmem_wdata)
	);

endmodule

/* tests/pmem_model.sv */
module pmem_model #(
	parameter int seed_init = 1
) (
	input  logic             clk,
	input  logic             reset_hits,
	input  logic             pmem_read,
	input  logic             pmem_write,
	input  cache_pkg::addr_t pmem_address,
	input  cache_pkg::line_t pmem_wdata,
	output cache_pkg::line_t pmem_rdata,
	output logic             pmem_resp,
	output int               read_count,
	output int               write_count
);
	timeunit 1ns;
	timeprecision 1ns;
	import cache_pkg::*;

	localparam int num_lines = 4096; // Every line of the 16-bit space.

	line_t lines [num_lines];
	logic  busy;
	int    wait_count;
	int    seed;
	int    r;

	function automatic word_t preset_word(input addr_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'h5aa5;
	endfunction

	initial begin
		seed        = seed_init;
		busy        = 1'b0;
		wait_count  = 0;
		pmem_resp   = 1'b0;
		pmem_rdata  = '0;
		read_count  = 0;
		write_count = 0;
		for (int l = 0; l < num_lines; l++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				lines[l][w * WORD_BITS +: WORD_BITS] = preset_word({l[11:0], w[2:0], 1'b0});
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command handling on the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		if (reset_hits) begin
			busy        = 1'b0;
			pmem_resp   = 1'b0;
			read_count  = 0;
			write_count = 0;
		end else if (pmem_resp) begin
			pmem_resp = 1'b0; // One-cycle response.
		end else if (pmem_read || pmem_write) begin
			if (!busy) begin
				r          = $random(seed);
				wait_count = r & 7; // Extra cycles before the answer.
				busy       = 1'b1;
			end else if (wait_count != 0) begin
				wait_count = wait_count - 1;
			end else begin
				busy      = 1'b0;
				pmem_resp = 1'b1;
				if (pmem_write) begin
					lines[pmem_address[15:4]] = pmem_wdata;
					write_count               = write_count + 1;
				end else begin
					pmem_rdata = lines[pmem_address[15:4]];
					read_count = read_count + 1;
				end
			end
		end
	end

endmodule

/* tests/cache_tb.sv */
module cache_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import cache_pkg::*;

	localparam int num_requests = 400;
	localparam int max_cycles   = 200; // Worst case for one request.
	localparam int clk_period   = 40;
	localparam int reset_cycles = 3;
	localparam int start_seed   = 14;

	logic   clk;
	logic   reset_hits;
	logic   mem_read;
	logic   mem_write;
	addr_t  mem_address;
	word_t  mem_wdata;
	logic   mem_resp;
	word_t  mem_rdata;
	logic   pmem_read;
	logic   pmem_write;
	addr_t  pmem_address;
	line_t  pmem_wdata;
	logic   pmem_resp;
	line_t  pmem_rdata;
	count_t hit_count;
	count_t miss_count;
	int     read_count;
	int     write_count;
	int     seed;

	// Flat memory truth and the per-set cache model.
	word_t flat_mem    [32768];
	tag_t  model_tag   [NUM_SETS][2];
	logic  model_valid [NUM_SETS][2];
	logic  model_dirty [NUM_SETS][2];
	logic  model_lru   [NUM_SETS]; // Way to replace next.
	int    exp_hits;
	int    exp_misses;
	int    exp_writebacks;

	tag_t tag_pool [4] = '{9'h000, 9'h0a5, 9'h15a, 9'h1ff}; // Four tags share two ways.

	cache #(
		.num_sets (NUM_SETS)
	) u_dut (
		.clk          (clk),
		.reset_hits   (reset_hits),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.mem_resp     (mem_resp),
		.mem_rdata    (mem_rdata),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata),
		.hit_count    (hit_count),
		.miss_count   (miss_count)
	);

	pmem_model #(
		.seed_init (start_seed)
	) u_mem (
		.clk          (clk),
		.reset_hits   (reset_hits),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp),
		.read_count   (read_count),
		.write_count  (write_count)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else
			stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
	endtask

	function automatic word_t initial_word(input addr_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'h5aa5;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One request is predicted, driven, answered and checked
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_request(input logic is_write, input addr_t addr, input word_t data);
		tag_t  tag;
		set_t  set;
		logic  way;
		logic  first_hit;
		logic  wb_due;
		addr_t wb_addr;
		logic  done;
		tag       = addr[15:7];
		set       = addr[6:4];
		way       = model_lru[set];
		first_hit = 1'b0;
		wb_due    = 1'b0;
		wb_addr   = '0;
		done      = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[set][w] && model_tag[set][w] == tag) begin
				first_hit = 1'b1;
				way       = w[0];
			end
		end
		if (first_hit) begin
			exp_hits++;
		end else begin
			exp_misses++;
			if (model_valid[set][way] && model_dirty[set][way]) begin
				wb_due  = 1'b1;
				wb_addr = {model_tag[set][way], set, 4'h0};
				exp_writebacks++;
			end
			model_tag[set][way]   = tag;
			model_valid[set][way] = 1'b1;
			model_dirty[set][way] = 1'b0;
		end
		model_lru[set] = ~way;
		if (is_write) begin
			model_dirty[set][way] = 1'b1;
		end

		mem_address = addr;
		mem_wdata   = data;
		mem_read    = ~is_write;
		mem_write   = is_write;
		while (!done) begin
			@(posedge clk);
			if (pmem_write && pmem_resp) begin
				assert (wb_due) else stop_on_error("write-back with no dirty victim expected");
				check_value("write-back address", 32'(wb_addr), 32'(pmem_address));
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					check_value("write-back data", 32'(flat_mem[{wb_addr[15:4], w[2:0]}]),
						32'(pmem_wdata[w * WORD_BITS +: WORD_BITS]));
				end
				wb_due = 1'b0;
			end
			if (pmem_read && pmem_resp) begin
				assert (!first_hit) else stop_on_error("line fill for a request that should hit");
				check_value("fill address", 32'({tag, set, 4'h0}), 32'(pmem_address));
			end
			if (mem_resp) begin
				done = 1'b1;
				if (is_write) begin
					flat_mem[addr[15:1]] = data;
				end else begin
					check_value("read data", 32'(flat_mem[addr[15:1]]), 32'(mem_rdata));
				end
			end
		end
		@(negedge clk);
		mem_read  = 1'b0;
		mem_write = 1'b0;
		@(posedge clk);
		assert (!mem_resp) else stop_on_error("mem_resp arrived with no request present");
		check_value("line reads", exp_misses, read_count);
		check_value("line writes", exp_writebacks, write_count);
		@(negedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int    r;
		logic  is_write;
		addr_t addr;
		word_t data;
		seed           = start_seed;
		reset_hits     = 1'b1;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		mem_address    = '0;
		mem_wdata      = '0;
		exp_hits       = 0;
		exp_misses     = 0;
		exp_writebacks = 0;
		for (int i = 0; i < 32768; i++) begin
			flat_mem[i] = initial_word({i[14:0], 1'b0});
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				model_tag[s][w]   = '0;
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
			end
		end

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_hits = 1'b0;
		@(posedge clk);
		check_value("hit_count after reset", 0, 32'(hit_count));
		check_value("miss_count after reset", 0, 32'(miss_count));
		assert (!mem_resp && !pmem_read && !pmem_write) else
			stop_on_error("handshake outputs not low after reset");
		@(negedge clk);

		for (int n = 0; n < num_requests; n++) begin
			r        = $random(seed);
			is_write = r[9]; // Roughly half reads.
			addr     = {tag_pool[r[1:0]], r[4:2], r[7:5], r[8]};
			data     = r[31:16];
			run_request(is_write, addr, data);
		end

		check_value("miss_count", exp_misses, 32'(miss_count));
		check_value("hit_count", exp_hits, 32'(hit_count));
		$display("Verification passed");
		$finish;
	end

	initial begin
		#((num_requests * max_cycles + 10) * clk_period);
		stop_on_error("watchdog expired before all requests completed");
	end

endmodule

/* cache.f */
design/cache_pkg.sv
design/cache_way.sv
design/cache_control.sv
design/cache_datapath.sv
design/cache.sv
tests/pmem_model.sv
tests/cache_tb.sv

/* Makefile */
# Verilator build and run for the cache testbench.

VERILATOR ?= verilator
TOP       ?= cache_tb
FILE_LIST ?= cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_TEXT ?= Verification passed

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Fails unless the pass message shows up as a line of its own.
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
